//--- audio_engine.f
rtl/audio_pkg.sv
rtl/audio_ram.sv
rtl/host_port.sv
rtl/prog_counter.sv
rtl/mac_unit.sv
rtl/mix_sequencer.sv
rtl/audio_engine.sv
testbench/audio_engine_tb.sv

//--- Makefile
# Verilator build of the audio mixing engine

TOP = audio_engine_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module audio_engine -f audio_engine.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f audio_engine.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/audio_engine_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench of the audio mixing engine
// Expected slots come from a software model of program and input RAM
// One bus access at a time, each bounded by a ready timeout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_engine_tb import audio_pkg::*; ();

    logic        ck;
    logic        rst;
    logic        iomem_valid;
    logic [3:0]  iomem_wstrb;
    logic [31:0] iomem_addr;
    logic [31:0] iomem_wdata;
    logic        iomem_ready;
    logic [31:0] iomem_rdata;

    logic [31:0] lfsr_state;
    int          sample_mem [n_chan * n_frame];
    instr_t      prog [n_code];
    int          prog_len;
    int          exp_slot [n_chan];
    bit          slot_saved [n_chan];
    int          errors;
    int          checks;
    int          tests_bad;
    int          test_start;
    bit          busy_seen;

    audio_engine i_audio_engine (
        .ck(ck), .rst(rst), .iomem_valid(iomem_valid), .iomem_wstrb(iomem_wstrb),
        .iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata),
        .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata)
    );

    always #5 ck = ~ck;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int rand_sample();
        return int'($signed(16'(rand_bits(16))));
    endfunction

    function automatic instr_t make_instr(opcode_e op, int chan, int delay, int gain);
        instr_t w;
        w.op     = op;
        w.chan   = 4'(chan);
        w.delay  = 5'(delay);
        w.unused = 5'd0;
        w.gain   = 16'(gain);
        return w;
    endfunction

    function automatic logic [31:0] word_addr(logic [15:0] region, int index);
        return {region, 16'h0000} + 32'(index * 4);
    endfunction

    // Floor of sum / 32768, then clamped to the sample range
    function automatic int floor_scale_clamp(longint sum);
        longint q;
        q = sum / 32768;
        if (sum < 0 && q * 32768 != sum) begin
            q = q - 1;
        end
        if (q > 32767) begin
            return 32767;
        end
        if (q < -32768) begin
            return -32768;
        end
        return int'(q);
    endfunction

    // Walks the program like the engine does, up to HALT
    function automatic void model_run(logic [4:0] frame);
        longint     acc;
        logic [4:0] src;
        acc = 0;
        for (int s = 0; s < n_chan; s++) begin
            slot_saved[s] = 1'b0;
        end
        for (int i = 0; i < prog_len; i++) begin
            src = frame - prog[i].delay;
            if (prog[i].op == op_mac) begin
                acc += longint'(sample_mem[{prog[i].chan, src}]) * longint'(prog[i].gain);
            end else if (prog[i].op == op_save) begin
                exp_slot[prog[i].chan]   = floor_scale_clamp(acc);
                slot_saved[prog[i].chan] = 1'b1;
                acc = 0;
            end else begin
                break;
            end
        end
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic expect_equal(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge ck);
        iomem_valid <= 1'b1;
        iomem_addr  <= addr;
        iomem_wdata <= wdata;
        iomem_wstrb <= wstrb;
        do begin
            @(negedge ck);
            n++;
        end while (!iomem_ready && n < 20);
        if (!iomem_ready) begin
            stop_on_timeout($sformatf("no bus ready for address %h", addr));
        end else begin
            rdata = iomem_rdata;
            @(posedge ck);
            iomem_valid <= 1'b0;
            iomem_wstrb <= 4'h0;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_data;
        bus_access(addr, wdata, 4'hf, unused_data);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, 32'h0, 4'h0, rdata);
    endtask

    task automatic write_sample(input int chan, input int frame, input int value);
        int idx;
        idx = chan * n_frame + frame;
        sample_mem[idx] = value;
        bus_write(word_addr(region_audio, idx), 32'(value));
    endtask

    task automatic write_program();
        for (int i = 0; i < prog_len; i++) begin
            bus_write(word_addr(region_coef, i), 32'(prog[i]));
        end
    endtask

    // Start through the control word, then poll status until done
    task automatic run_program(input logic [4:0] frame, output status_t st, output bit busy);
        logic [31:0] d;
        int          n;
        bus_write(word_addr(region_control, 0), 32'(frame));
        n = 0;
        busy = 1'b0;
        do begin
            bus_read(word_addr(region_status, 0), d);
            if (n == 0) begin
                busy = !d[0];
            end
            n++;
        end while (!d[0] && n < 400);
        if (!d[0]) begin
            stop_on_timeout("mix program never reported done");
        end else begin
            st = status_t'(d[1:0]);
        end
    endtask

    task automatic check_slots();
        logic [31:0] d;
        for (int s = 0; s < n_chan; s++) begin
            if (slot_saved[s]) begin
                bus_read(word_addr(region_result, s), d);
                expect_equal(int'($signed(d[15:0])), exp_slot[s],
                             $sformatf("result slot %0d", s));
            end
        end
    endtask

    task automatic run_and_check(input logic [4:0] frame, output bit busy);
        status_t st;
        write_program();
        model_run(frame);
        run_program(frame, st, busy);
        expect_equal(int'(st), 1, "status after mix run");
        check_slots();
    endtask

    // Four groups of three MACs with nonzero delays, each saved to its own slot
    task automatic build_random_program();
        int k;
        k = 0;
        for (int s = 0; s < 4; s++) begin
            for (int m = 0; m < 3; m++) begin
                prog[k] = make_instr(op_mac, int'(rand_bits(4)), int'(rand_bits(5) | 32'd1),
                                     rand_sample());
                k++;
            end
            prog[k] = make_instr(op_save, 4 * s + int'(rand_bits(2)), 0, 0);
            k++;
        end
        prog[k] = make_instr(op_halt, 0, 0, 0);
        prog_len = k + 1;
    endtask

    task automatic report_test(input string name);
        if (errors == test_start) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic idle_after_reset();
        logic [31:0] d;
        @(negedge ck);
        expect_equal(int'(iomem_ready), 0, "ready after reset");
        bus_read(word_addr(region_status, 0), d);
        expect_equal(int'(d), 0, "status after reset");
    endtask

    task automatic single_mac_to_slot();
        prog[0]  = make_instr(op_mac, 3, 0, 'h4000);
        prog[1]  = make_instr(op_save, 5, 0, 0);
        prog[2]  = make_instr(op_halt, 0, 0, 0);
        prog_len = 3;
        run_and_check(5'd7, busy_seen);
    endtask

    task automatic saturate_mix();
        status_t     st;
        logic [31:0] d;
        for (int c = 0; c < 4; c++) begin
            prog[c] = make_instr(op_mac, c + 8, 0, 32767);
        end
        prog[4]  = make_instr(op_save, 12, 0, 0);
        prog[5]  = make_instr(op_halt, 0, 0, 0);
        prog_len = 6;
        write_program();
        for (int neg = 0; neg < 2; neg++) begin
            for (int c = 0; c < 4; c++) begin
                write_sample(c + 8, 20, neg == 0 ? 32767 : -32767);
            end
            run_program(5'd20, st, busy_seen);
            expect_equal(int'(st), 1, "status after saturating run");
            bus_read(word_addr(region_result, 12), d);
            expect_equal(int'($signed(d[15:0])), neg == 0 ? 32767 : -32768, "saturated slot");
        end
    endtask

    task automatic error_flags();
        status_t st;
        prog[0]  = make_instr(op_rsvd, 0, 0, 0);
        prog_len = 1;
        write_program();
        run_program(5'd0, st, busy_seen);
        expect_equal(int'(st), 3, "status after reserved opcode");
        // No HALT, so the counter steps past the last word
        for (int i = 0; i < n_code; i++) begin
            prog[i] = make_instr(op_mac, i % n_chan, i % n_frame, 1);
        end
        prog_len = n_code;
        write_program();
        run_program(5'd0, st, busy_seen);
        expect_equal(int'(st), 3, "status after program overrun");
    endtask

    task automatic restart_mix();
        build_random_program();
        // MAC after the last SAVE leaves the accumulator loaded when the run ends
        prog[prog_len - 1] = make_instr(op_mac, 0, 0, 'h7fff);
        prog[prog_len]     = make_instr(op_halt, 0, 0, 0);
        prog_len++;
        run_and_check(5'd1, busy_seen);
        for (int i = 0; i < prog_len; i++) begin
            if (prog[i].op == op_mac) begin
                prog[i].gain = 16'(rand_sample());
            end
        end
        run_and_check(5'd1, busy_seen);
        expect_equal(int'(busy_seen), 1, "done cleared while running");
    endtask

    initial begin
        ck          = 1'b0;
        rst         = 1'b1;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
        iomem_addr  = 32'h0;
        iomem_wdata = 32'h0;
        lfsr_state  = 32'hd02d_39d7;
        errors      = 0;
        checks      = 0;
        tests_bad   = 0;
        test_start  = 0;
        repeat (3) @(posedge ck);
        rst <= 1'b0;

        idle_after_reset();
        report_test("reset state");
        for (int i = 0; i < n_chan * n_frame; i++) begin
            write_sample(i / n_frame, i % n_frame, rand_sample());
        end
        single_mac_to_slot();
        report_test("single mac");
        // Low frame so most delays wrap below frame 0
        build_random_program();
        run_and_check(5'(rand_bits(2)), busy_seen);
        report_test("random mix");
        saturate_mix();
        report_test("saturation");
        error_flags();
        report_test("error status");
        restart_mix();
        report_test("restart");

        $display("Tests run: 6, with mismatches: %0d, checks: %0d, mismatches: %0d",
                 tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/audio_engine.sv
//////////////////////////////////////////////////////////////////////
// Memory-mapped audio mixing engine, top level
// Host fills the program and input RAMs, then starts a run
// through the control word and polls status for done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_engine import audio_pkg::*; (
    input  logic        ck,
    input  logic        rst,
    input  logic        iomem_valid,
    input  logic [3:0]  iomem_wstrb,
    input  logic [31:0] iomem_addr,
    input  logic [31:0] iomem_wdata,
    output logic        iomem_ready,
    output logic [31:0] iomem_rdata
);

    bus_req_t           req;
    logic               coef_we, audio_we, res_we, start;
    logic [code_w-1:0]  coef_waddr, coef_raddr;
    logic [audio_w-1:0] audio_waddr, audio_raddr;
    logic [chan_w-1:0]  res_waddr, res_raddr;
    logic [frame_w-1:0] frame;
    instr_t             coef_wdata, coef_rdata;
    sample_t            audio_wdata, audio_rdata, res_wdata, res_rdata;
    status_t            status;

    assign req = '{valid: iomem_valid, wstrb: iomem_wstrb,
                   addr: iomem_addr, wdata: iomem_wdata};

    host_port i_host_port (
        .ck(ck), .rst(rst), .req(req), .ready(iomem_ready), .rdata(iomem_rdata),
        .coef_we(coef_we), .coef_waddr(coef_waddr), .coef_wdata(coef_wdata),
        .audio_we(audio_we), .audio_waddr(audio_waddr), .audio_wdata(audio_wdata),
        .res_raddr(res_raddr), .res_rdata(res_rdata), .status(status),
        .frame(frame), .start(start)
    );

    // Program memory
    audio_ram #(.word_t(instr_t), .depth(n_code)) i_coef_ram (
        .ck(ck), .we(coef_we), .waddr(coef_waddr), .wdata(coef_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    // Input samples, channel by frame
    audio_ram #(.word_t(sample_t), .depth(n_chan * n_frame)) i_audio_ram (
        .ck(ck), .we(audio_we), .waddr(audio_waddr), .wdata(audio_wdata),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

    // Result slots
    audio_ram #(.word_t(sample_t), .depth(n_chan)) i_result_ram (
        .ck(ck), .we(res_we), .waddr(res_waddr), .wdata(res_wdata),
        .raddr(res_raddr), .rdata(res_rdata)
    );

    mix_sequencer i_mix_sequencer (
        .ck(ck), .rst(rst), .start(start), .frame(frame),
        .coef_raddr(coef_raddr), .coef_rdata(coef_rdata),
        .audio_raddr(audio_raddr), .audio_rdata(audio_rdata),
        .res_we(res_we), .res_waddr(res_waddr), .res_wdata(res_wdata),
        .status(status)
    );

endmodule

//--- rtl/mix_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Mix program sequencer
// MAC and SAVE take three clocks, HALT two and then done is set
// Reserved opcode or a step past the last word sets error and done
// A start pulse restarts the program from word 0 at any time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mix_sequencer import audio_pkg::*; (
    input  logic               ck,
    input  logic               rst,
    input  logic               start,
    input  logic [frame_w-1:0] frame,
    output logic [code_w-1:0]  coef_raddr,
    input  instr_t             coef_rdata,
    output logic [audio_w-1:0] audio_raddr,
    input  sample_t            audio_rdata,
    output logic               res_we,
    output logic [chan_w-1:0]  res_waddr,
    output sample_t            res_wdata,
    output status_t            status
);

    typedef enum logic [2:0] {idle, fetch, read, exec, save_wait, finish} state_e;

    state_e             state;
    logic               done, error;
    logic               pc_step;
    logic               overrun;
    logic               mac_clear;
    logic [frame_w-1:0] src_frame;

    // pc holds until the instruction completes, so coef_rdata stays valid
    prog_counter i_prog_counter (
        .ck(ck), .rst(rst), .clear(start), .step(pc_step),
        .pc(coef_raddr), .overrun(overrun)
    );

    // Delayed frame wraps modulo the frame count
    assign src_frame   = frame - coef_rdata.delay;
    assign audio_raddr = {coef_rdata.chan, src_frame};

    assign pc_step   = !start && (state == exec || state == save_wait);
    assign mac_clear = start || (state == save_wait);

    mac_unit i_mac_unit (
        .ck(ck), .rst(rst), .clear(mac_clear), .acc_en(state == exec),
        .sample(audio_rdata), .gain(coef_rdata.gain), .result(res_wdata)
    );

    assign res_we    = (state == save_wait);
    assign res_waddr = coef_rdata.chan;
    assign status    = '{error: error, done: done};

    always_ff @(posedge ck) begin
        if (rst) begin
            state <= idle;
            done  <= 1'b0;
            error <= 1'b0;
        end else if (start) begin
            state <= fetch;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                fetch: begin
                    if (overrun) begin
                        error <= 1'b1;
                        state <= finish;
                    end else begin
                        state <= read;
                    end
                end
                read: begin
                    case (coef_rdata.op)
                        op_mac:  state <= exec;
                        op_save: state <= save_wait;
                        op_halt: state <= finish;
                        default: begin
                            error <= 1'b1;
                            state <= finish;
                        end
                    endcase
                end
                exec, save_wait: state <= fetch;
                finish: begin
                    done  <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // The SAVE word stays on the program RAM output until its slot is written
    a_save_write: assert property (@(posedge ck) disable iff (rst)
        res_we |-> (coef_rdata.op == op_save) && $stable(coef_rdata.chan));

endmodule

//--- rtl/mac_unit.sv
//////////////////////////////////////////////////////////////////////
// Signed multiply-accumulate for Q1.15 gains
// Result is acc >>> 15 clamped to 16 bits, one clock behind acc
// Clear has priority over accumulate
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_unit import audio_pkg::*; (
    input  logic    ck,
    input  logic    rst,
    input  logic    clear,
    input  logic    acc_en,
    input  sample_t sample,
    input  sample_t gain,
    output sample_t result
);

    logic signed [31:0]      product;
    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] scaled;

    assign product = sample * gain;
    assign scaled  = acc >>> 15;

    always_ff @(posedge ck) begin
        if (rst || clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + product;
        end
    end

    // Saturate to the sample range
    always_ff @(posedge ck) begin
        if (scaled > sample_max) begin
            result <= sample_t'(sample_max);
        end else if (scaled < sample_min) begin
            result <= sample_t'(sample_min);
        end else begin
            result <= scaled[15:0];
        end
    end

endmodule

//--- rtl/prog_counter.sv
//////////////////////////////////////////////////////////////////////
// Program address counter of the mix sequencer
// Overrun sets on a step from the last program word, held until clear
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module prog_counter import audio_pkg::*; (
    input  logic              ck,
    input  logic              rst,
    input  logic              clear,
    input  logic              step,
    output logic [code_w-1:0] pc,
    output logic              overrun
);

    always_ff @(posedge ck) begin
        if (rst || clear) begin
            pc      <= '0;
            overrun <= 1'b0;
        end else if (step) begin
            // Address wraps, the flag records it
            if (pc == code_w'(n_code - 1)) begin
                overrun <= 1'b1;
            end
            pc <= pc + 1'b1;
        end
    end

    a_clear_step: assert property (@(posedge ck) disable iff (rst) !(clear && step));

endmodule

//--- rtl/host_port.sv
//////////////////////////////////////////////////////////////////////
// Bus slave of the audio engine
// Ready is a single-cycle pulse two clocks after valid is first seen
// Valid and the request must be held until ready, byte lanes ignored
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module host_port import audio_pkg::*; (
    input  logic                ck,
    input  logic                rst,
    input  bus_req_t            req,
    output logic                ready,
    output logic [31:0]         rdata,
    output logic                coef_we,
    output logic [code_w-1:0]   coef_waddr,
    output instr_t              coef_wdata,
    output logic                audio_we,
    output logic [audio_w-1:0]  audio_waddr,
    output sample_t             audio_wdata,
    output logic [chan_w-1:0]   res_raddr,
    input  sample_t             res_rdata,
    input  status_t             status,
    output logic [frame_w-1:0]  frame,
    output logic                start
);

    logic        busy;
    logic        fire;
    logic        wr;
    logic        p1, p2;
    logic        rd_res, rd_stat;
    logic [31:0] data_q;

    // A held valid starts only one access
    assign fire = req.valid && !busy;
    assign wr   = |req.wstrb;

    assign coef_we     = fire && wr && (req.addr[31:16] == region_coef);
    assign coef_waddr  = req.addr[2+code_w-1:2];
    assign coef_wdata  = instr_t'(req.wdata);
    assign audio_we    = fire && wr && (req.addr[31:16] == region_audio);
    assign audio_waddr = req.addr[2+audio_w-1:2];
    assign audio_wdata = sample_t'(req.wdata[15:0]);
    assign res_raddr   = req.addr[2+chan_w-1:2];

    always_ff @(posedge ck) begin
        if (rst) begin
            busy  <= 1'b0;
            p1    <= 1'b0;
            p2    <= 1'b0;
            ready <= 1'b0;
            rdata <= '0;
            start <= 1'b0;
            frame <= '0;
        end else begin
            if (ready) begin
                busy <= 1'b0;
            end else if (fire) begin
                busy <= 1'b1;
            end
            p1    <= fire;
            p2    <= p1;
            ready <= p2;
            rdata <= p2 ? data_q : '0;
            start <= fire && wr && (req.addr[31:16] == region_control);
            if (fire && wr && (req.addr[31:16] == region_control)) begin
                frame <= req.wdata[frame_w-1:0];
            end
        end
    end

    // Read select and data, result RAM output is valid one clock after fire
    always_ff @(posedge ck) begin
        if (fire) begin
            rd_res  <= !wr && (req.addr[31:16] == region_result);
            rd_stat <= !wr && (req.addr[31:16] == region_status);
        end
        if (p1) begin
            data_q <= rd_res  ? {16'h0000, res_rdata} :
                      rd_stat ? {30'h0, status} : '0;
        end
    end

    a_ready_pulse: assert property (@(posedge ck) disable iff (rst) ready |=> !ready);

endmodule

//--- rtl/audio_ram.sv
//////////////////////////////////////////////////////////////////////
// Simple dual-port RAM, one write port and one registered read port
// Read data follows raddr by one clock, contents undefined at reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_ram #(
    parameter type word_t = logic [31:0],
    parameter int  depth  = 256
) (
    input  logic                     ck,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [depth];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read of a location written in the same cycle returns the old word
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/audio_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared address map, sizes and types of the audio mixing engine
// Regions are matched on address bits 31..16 only
// Gains are signed Q1.15, samples signed 16 bit
//////////////////////////////////////////////////////////////////////

package audio_pkg;

    // Upper address bits of the peripheral and its regions
    localparam logic [15:0] base_addr      = 16'h6000;
    localparam logic [15:0] region_coef    = base_addr + 16'h0000;
    localparam logic [15:0] region_audio   = base_addr + 16'h0100;
    localparam logic [15:0] region_result  = base_addr + 16'h0200;
    localparam logic [15:0] region_status  = base_addr + 16'h0300;
    localparam logic [15:0] region_control = base_addr + 16'h0400;

    localparam int n_chan  = 16;
    localparam int chan_w  = 4;
    localparam int n_frame = 32;
    localparam int frame_w = 5;
    localparam int n_code  = 256;
    localparam int code_w  = 8;
    // Channel in the upper bits, frame in the lower bits
    localparam int audio_w = 9;
    localparam int acc_w   = 40;

    // Output clamp limits
    localparam int sample_max = 32767;
    localparam int sample_min = -32768;

    typedef logic signed [15:0] sample_t;

    typedef enum logic [1:0] {
        op_halt = 2'd0,
        op_mac  = 2'd1,
        op_save = 2'd2,
        op_rsvd = 2'd3
    } opcode_e;

    // For save the chan field picks the result slot
    typedef struct packed {
        opcode_e              op;
        logic [chan_w-1:0]    chan;
        logic [frame_w-1:0]   delay;
        logic [4:0]           unused;
        sample_t              gain;
    } instr_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic error;
        logic done;
    } status_t;

endpackage
